/* pque_defines.svh */
`ifndef PQUE_DEFINES_SVH
`define PQUE_DEFINES_SVH

// data word width
`define WIDTH 32

// shared buffer entries and pointer width
`define NUMADDR 64
`define BITADDR 6

// queues
`define NUMQPRT 8
`define BITQPRT 3

// one extra bit so a queue can hold the whole buffer
`define BITQCNT (`BITADDR+1)

`endif

/* pque_pkg.sv */
`include "pque_defines.svh"

package pque_pkg;

  // stored word
  typedef logic [`WIDTH-1:0] data_t;

  // buffer pointer, also the memory address
  typedef logic [`BITADDR-1:0] qptr_t;

  // queue number
  typedef logic [`BITQPRT-1:0] qprt_t;

  // queue occupancy, 0 up to NUMADDR
  typedef logic [`BITQCNT-1:0] qcnt_t;

endpackage

/* pque_ram.sv */
`include "pque_defines.svh"

module pque_ram #(
  parameter int DW = `WIDTH
) (
  input  logic            clk,
  input  logic            wr,
  input  pque_pkg::qptr_t waddr,
  input  logic [DW-1:0]   wdata,
  input  pque_pkg::qptr_t raddr,
  output logic [DW-1:0]   rdata
);

  logic [DW-1:0] mem [`NUMADDR];

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, a write on the same edge is passed through
  always_ff @(posedge clk) begin
    if (wr && (waddr == raddr)) begin
      rdata <= wdata;
    end else begin
      rdata <= mem[raddr];
    end
  end

endmodule

/* pque_state.sv */
`include "pque_defines.svh"

module pque_state (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            push,
  input  pque_pkg::qprt_t pu_prt,
  input  pque_pkg::qptr_t pu_ptr,
  input  logic            pop,
  input  pque_pkg::qprt_t po_prt,
  input  logic            hd_upd,
  input  pque_pkg::qprt_t hd_qprt,
  input  pque_pkg::qptr_t hd_next,
  output logic            link_wr,
  output pque_pkg::qptr_t link_waddr,
  output pque_pkg::qptr_t head_ptr,
  output logic            pop_take,
  output logic            pop_relink,
  output pque_pkg::qcnt_t cnt_next,
  output logic            pu_cvld,
  output pque_pkg::qcnt_t pu_cnt
);

  pque_pkg::qptr_t head_q [`NUMQPRT];
  pque_pkg::qptr_t tail_q [`NUMQPRT];
  pque_pkg::qcnt_t cnt_q  [`NUMQPRT];
  pque_pkg::qcnt_t cnt_d  [`NUMQPRT];

  pque_pkg::qcnt_t po_cur;  // count of popped queue, before this cycle
  pque_pkg::qcnt_t pu_cur;  // count of pushed queue, before this cycle
  logic            pu_hit;

  assign po_cur = cnt_q[po_prt];
  assign pu_cur = cnt_q[pu_prt];

  assign pop_take   = pop && (po_cur != '0);
  // head moves on via the link memory only if something stays behind it
  assign pop_relink = pop_take && (po_cur > pque_pkg::qcnt_t'(1));
  assign head_ptr   = head_q[po_prt];

  // old tail points at the new entry
  assign link_wr    = push && (pu_cur != '0);
  assign link_waddr = tail_q[pu_prt];

  // new entry becomes the head: empty queue, or last entry leaving now
  assign pu_hit = push && ((pu_cur == '0) ||
                           ((pu_cur == pque_pkg::qcnt_t'(1)) && pop_take &&
                            (po_prt == pu_prt)));

  always_comb begin
    for (int q = 0; q < `NUMQPRT; q++) begin
      cnt_d[q] = cnt_q[q];
      if (push && (pu_prt == pque_pkg::qprt_t'(q))) begin
        cnt_d[q] = cnt_d[q] + pque_pkg::qcnt_t'(1);
      end
      if (pop_take && (po_prt == pque_pkg::qprt_t'(q))) begin
        cnt_d[q] = cnt_d[q] - pque_pkg::qcnt_t'(1);
      end
    end
  end

  assign cnt_next = cnt_d[po_prt];  // netted over push and pop

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int q = 0; q < `NUMQPRT; q++) begin
        cnt_q[q] <= '0;
      end
      pu_cvld <= 1'b0;
    end else begin
      for (int q = 0; q < `NUMQPRT; q++) begin
        cnt_q[q] <= cnt_d[q];
      end
      pu_cvld <= push;
    end
  end

  always_ff @(posedge clk) begin
    for (int q = 0; q < `NUMQPRT; q++) begin
      if (pu_hit && (pu_prt == pque_pkg::qprt_t'(q))) begin
        head_q[q] <= pu_ptr;
      end else if (hd_upd && (hd_qprt == pque_pkg::qprt_t'(q))) begin
        head_q[q] <= hd_next;  // refill from link read
      end
      if (push && (pu_prt == pque_pkg::qprt_t'(q))) begin
        tail_q[q] <= pu_ptr;
      end
    end
    pu_cnt <= cnt_d[pu_prt];
  end

endmodule

/* pque_deq.sv */
module pque_deq (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            pop,
  input  pque_pkg::qprt_t po_prt,
  input  logic            pop_take,
  input  logic            pop_relink,
  input  pque_pkg::qptr_t head_ptr,
  input  pque_pkg::qcnt_t cnt_next,
  input  pque_pkg::qptr_t link_rdata,
  input  pque_pkg::data_t data_rdata,
  output logic            hd_upd,
  output pque_pkg::qprt_t hd_qprt,
  output pque_pkg::qptr_t hd_next,
  output logic            po_cvld,
  output logic            po_cmt,
  output pque_pkg::qcnt_t po_cnt,
  output pque_pkg::qptr_t po_ptr,
  output logic            po_dvld,
  output pque_pkg::data_t po_dout
);

  logic take_q;  // stage one holds a real dequeue

  // stage one control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      po_cvld <= 1'b0;
      hd_upd  <= 1'b0;
      take_q  <= 1'b0;
    end else begin
      po_cvld <= pop;
      hd_upd  <= pop_relink;
      take_q  <= pop_take;
    end
  end

  // stage one results
  always_ff @(posedge clk) begin
    po_cmt  <= !pop_take;
    po_cnt  <= cnt_next;
    po_ptr  <= head_ptr;
    hd_qprt <= po_prt;
  end

  // link read lands now, that is the next head of hd_qprt
  assign hd_next = link_rdata;

  // stage two, word from data memory
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      po_dvld <= 1'b0;
    end else begin
      po_dvld <= take_q;
    end
  end

  always_ff @(posedge clk) begin
    po_dout <= data_rdata;
  end

endmodule

/* pque_top.sv */
`include "pque_defines.svh"

module pque_top (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            push,
  input  pque_pkg::qprt_t pu_prt,
  input  pque_pkg::qptr_t pu_ptr,
  input  pque_pkg::data_t pu_din,
  input  logic            pop,
  input  pque_pkg::qprt_t po_prt,
  output logic            pu_cvld,
  output pque_pkg::qcnt_t pu_cnt,
  output logic            po_cvld,
  output logic            po_cmt,
  output pque_pkg::qcnt_t po_cnt,
  output pque_pkg::qptr_t po_ptr,
  output logic            po_dvld,
  output pque_pkg::data_t po_dout
);

  logic            link_wr;
  pque_pkg::qptr_t link_waddr;
  pque_pkg::qptr_t link_rdata;
  pque_pkg::qptr_t head_ptr;   // read address of both memories
  logic            pop_take;
  logic            pop_relink;
  pque_pkg::qcnt_t cnt_next;
  logic            hd_upd;
  pque_pkg::qprt_t hd_qprt;
  pque_pkg::qptr_t hd_next;
  pque_pkg::data_t data_rdata;

  pque_state u_state (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (push),
    .pu_prt     (pu_prt),
    .pu_ptr     (pu_ptr),
    .pop        (pop),
    .po_prt     (po_prt),
    .hd_upd     (hd_upd),
    .hd_qprt    (hd_qprt),
    .hd_next    (hd_next),
    .link_wr    (link_wr),
    .link_waddr (link_waddr),
    .head_ptr   (head_ptr),
    .pop_take   (pop_take),
    .pop_relink (pop_relink),
    .cnt_next   (cnt_next),
    .pu_cvld    (pu_cvld),
    .pu_cnt     (pu_cnt)
  );

  pque_deq u_deq (
    .clk        (clk),
    .rst_n      (rst_n),
    .pop        (pop),
    .po_prt     (po_prt),
    .pop_take   (pop_take),
    .pop_relink (pop_relink),
    .head_ptr   (head_ptr),
    .cnt_next   (cnt_next),
    .link_rdata (link_rdata),
    .data_rdata (data_rdata),
    .hd_upd     (hd_upd),
    .hd_qprt    (hd_qprt),
    .hd_next    (hd_next),
    .po_cvld    (po_cvld),
    .po_cmt     (po_cmt),
    .po_cnt     (po_cnt),
    .po_ptr     (po_ptr),
    .po_dvld    (po_dvld),
    .po_dout    (po_dout)
  );

  // next-pointer list
  pque_ram #(.DW(`BITADDR)) link_ram (
    .clk   (clk),
    .wr    (link_wr),
    .waddr (link_waddr),
    .wdata (pu_ptr),
    .raddr (head_ptr),
    .rdata (link_rdata)
  );

  // word store, written at the pushed pointer
  pque_ram #(.DW(`WIDTH)) data_ram (
    .clk   (clk),
    .wr    (push),
    .waddr (pu_ptr),
    .wdata (pu_din),
    .raddr (head_ptr),
    .rdata (data_rdata)
  );

endmodule

/* tb_pque.sv */
`include "pque_defines.svh"

module tb_pque;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 20;
  localparam int RST_CYCLES   = 10;
  localparam int IDLE_CYCLES  = 5;
  localparam int SAME_CYCLES  = 12;
  localparam int RAND_CYCLES  = 4000;
  localparam int DRAIN_MAX    = 2 * `NUMADDR + 2;  // one queue holding everything
  // empty pops, same-cycle cases, fill, random traffic, three drains and a flush
  localparam int TOTAL_CYCLES = RST_CYCLES + IDLE_CYCLES + `NUMQPRT + SAME_CYCLES +
                                `NUMADDR + 1 + RAND_CYCLES + 3 * DRAIN_MAX + 3;

  logic            clk;
  logic            rst_n;
  logic            push;
  pque_pkg::qprt_t pu_prt;
  pque_pkg::qptr_t pu_ptr;
  pque_pkg::data_t pu_din;
  logic            pop;
  pque_pkg::qprt_t po_prt;
  logic            pu_cvld;
  pque_pkg::qcnt_t pu_cnt;
  logic            po_cvld;
  logic            po_cmt;
  pque_pkg::qcnt_t po_cnt;
  pque_pkg::qptr_t po_ptr;
  logic            po_dvld;
  pque_pkg::data_t po_dout;

  // reference model
  pque_pkg::qptr_t model_q [`NUMQPRT][$];  // pointers per queue with the head first
  pque_pkg::qptr_t free_pool [$];
  pque_pkg::data_t word_of [`NUMADDR];
  logic            dv_pend;                // word due on the next cycle
  pque_pkg::data_t dv_word;
  logic            last_pop;
  pque_pkg::qprt_t last_prt;
  logic [31:0]     seed;
  string           test_name;

  pque_top dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .push    (push),
    .pu_prt  (pu_prt),
    .pu_ptr  (pu_ptr),
    .pu_din  (pu_din),
    .pop     (pop),
    .po_prt  (po_prt),
    .pu_cvld (pu_cvld),
    .pu_cnt  (pu_cnt),
    .po_cvld (po_cvld),
    .po_cmt  (po_cmt),
    .po_cnt  (po_cnt),
    .po_ptr  (po_ptr),
    .po_dvld (po_dvld),
    .po_dout (po_dout)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string field, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else fail_run($sformatf("mismatch %s %s: expected %0h, actual %0h",
                              test_name, field, exp, act));
  endtask

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  push_strobe: assert property (@(posedge clk) disable iff (!rst_n) push |=> pu_cvld)
    else fail_run("push strobe was not followed by a push count valid");
  pop_strobe: assert property (@(posedge clk) disable iff (!rst_n) pop |=> po_cvld)
    else fail_run("pop strobe was not followed by a pop count valid");
  reset_quiet: assert property (@(posedge clk) !rst_n |=> !(pu_cvld || po_cvld || po_dvld))
    else fail_run("a valid output was high right after a reset cycle");

  // apply the inputs captured at the last edge and compare outputs
  task automatic check_cycle(input logic pu_v, input pque_pkg::qprt_t pu_q,
                             input pque_pkg::qptr_t pu_p, input pque_pkg::data_t pu_d,
                             input logic po_v, input pque_pkg::qprt_t po_q);
    logic            take;
    pque_pkg::qptr_t pp;
    pque_pkg::data_t pw;
    take = 1'b0;
    pp   = '0;
    pw   = '0;
    // pop sees the queue as it was before this cycle's push
    if (po_v && (model_q[po_q].size() != 0)) begin
      take = 1'b1;
      pp   = model_q[po_q].pop_front();
      pw   = word_of[pp];
    end
    if (pu_v) begin
      model_q[pu_q].push_back(pu_p);
      word_of[pu_p] = pu_d;
    end
    check_eq("pu_cvld", 32'(pu_v), 32'(pu_cvld));
    if (pu_v) begin
      check_eq("pu_cnt", model_q[pu_q].size(), 32'(pu_cnt));
    end
    check_eq("po_cvld", 32'(po_v), 32'(po_cvld));
    if (po_v) begin
      check_eq("po_cmt", 32'(!take), 32'(po_cmt));
      check_eq("po_cnt", model_q[po_q].size(), 32'(po_cnt));
    end
    if (take) begin
      check_eq("po_ptr", 32'(pp), 32'(po_ptr));
    end
    check_eq("po_dvld", 32'(dv_pend), 32'(po_dvld));
    if (dv_pend) begin
      check_eq("po_dout", dv_word, po_dout);
    end
    dv_pend = take;
    dv_word = pw;
    if (take) begin
      free_pool.push_back(pp);  // recycle
    end
  endtask

  // called 2 ns after an edge and checks after the next one
  task automatic run_cycle(input logic want_push, input pque_pkg::qprt_t pq,
                           input logic want_pop, input pque_pkg::qprt_t oq);
    int              idx;
    logic            pu_v;
    pque_pkg::qptr_t p;
    pque_pkg::data_t d;
    pu_v = want_push && (free_pool.size() != 0);
    p    = '0;
    d    = next_rand();
    if (pu_v) begin
      idx = int'(next_rand() % 32'(free_pool.size()));
      p   = free_pool[idx];
      free_pool.delete(idx);
    end
    // same queue may not be popped two cycles running
    if (want_pop && last_pop && (oq == last_prt)) begin
      oq = oq + pque_pkg::qprt_t'(1);
    end
    push     = pu_v;
    pu_prt   = pq;
    pu_ptr   = p;
    pu_din   = d;
    pop      = want_pop;
    po_prt   = oq;
    last_pop = want_pop;
    last_prt = oq;
    @(posedge clk);
    #2;
    check_cycle(pu_v, pq, p, d, want_pop, oq);
  endtask

  task automatic idle_cycle();
    run_cycle(1'b0, '0, 1'b0, '0);
  endtask

  task automatic drain_all();
    int found;
    int guard;
    guard = 0;
    while ((free_pool.size() != `NUMADDR) && (guard < DRAIN_MAX)) begin
      found = -1;
      for (int k = 1; k <= `NUMQPRT; k++) begin
        if ((found < 0) && (model_q[(int'(last_prt) + k) % `NUMQPRT].size() != 0) &&
            !(last_pop && (k == `NUMQPRT))) begin
          found = (int'(last_prt) + k) % `NUMQPRT;
        end
      end
      if (found < 0) begin
        idle_cycle();
      end else begin
        run_cycle(1'b0, '0, 1'b1, pque_pkg::qprt_t'(found));
      end
      guard++;
    end
  endtask

  initial begin
    #((TOTAL_CYCLES + 50) * CLK_PERIOD);
    fail_run("timeout, the stimulus did not finish in time");
  end

  initial begin
    logic [31:0] r;
    rst_n    = 1'b0;
    push     = 1'b0;
    pu_prt   = '0;
    pu_ptr   = '0;
    pu_din   = '0;
    pop      = 1'b0;
    po_prt   = '0;
    seed     = 32'h6c029e17;
    dv_pend  = 1'b0;
    dv_word  = '0;
    last_pop = 1'b0;
    last_prt = '0;
    for (int i = 0; i < `NUMADDR; i++) begin
      free_pool.push_back(pque_pkg::qptr_t'(i));
    end

    test_name = "reset";
    repeat (RST_CYCLES) begin
      @(posedge clk);
      #2;
      check_eq("pu_cvld", '0, 32'(pu_cvld));
      check_eq("po_cvld", '0, 32'(po_cvld));
      check_eq("po_dvld", '0, 32'(po_dvld));
    end
    rst_n = 1'b1;
    repeat (IDLE_CYCLES) idle_cycle();

    test_name = "empty pops";
    for (int q = 0; q < `NUMQPRT; q++) begin
      run_cycle(1'b0, '0, 1'b1, pque_pkg::qprt_t'(q));
    end

    test_name = "same-cycle push and pop";
    run_cycle(1'b1, 3'd3, 1'b1, 3'd3);  // push at count 0 not seen by pop
    idle_cycle();
    run_cycle(1'b1, 3'd3, 1'b1, 3'd3);  // pushed entry becomes the head at count 1
    idle_cycle();
    run_cycle(1'b0, '0, 1'b1, 3'd3);
    repeat (4) run_cycle(1'b1, 3'd3, 1'b0, '0);
    run_cycle(1'b1, 3'd3, 1'b1, 3'd3);  // count 4 stays 4
    run_cycle(1'b1, 3'd5, 1'b1, 3'd6);
    run_cycle(1'b1, 3'd3, 1'b1, 3'd3);
    drain_all();

    test_name = "fill all entries";
    repeat (`NUMADDR + 1) begin
      r = next_rand();
      run_cycle(1'b1, r[23:21], 1'b0, '0);
    end
    drain_all();

    test_name = "random traffic";
    repeat (RAND_CYCLES) begin
      r = next_rand();
      if (r[31:30] == 2'b11) begin
        run_cycle(r[20:18] < 3'd5, r[23:21], r[26:24] < 3'd5, r[23:21]);
      end else begin
        run_cycle(r[20:18] < 3'd5, r[23:21], r[26:24] < 3'd5, r[29:27]);
      end
    end
    drain_all();
    repeat (3) idle_cycle();  // let the last word come out

    $display("All tests passed");
    $finish;
  end

endmodule

/* list.f */
+incdir+.
pque_pkg.sv
pque_ram.sv
pque_state.sv
pque_deq.sv
pque_top.sv
tb_pque.sv

/* Makefile */
# Verilator build and run for the packet queue testbench

VERILATOR ?= verilator
TOP       ?= tb_pque
RTL_TOP   ?= pque_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --assert -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only if the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
